//--- exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN         32
`define EXU_DMEM_WORDS   256
`define EXU_DMEM_LAT     2

// opcode classes, as in the rv32 base encoding
`define OP_ALU           7'b0110011
`define OP_BRANCH        7'b1100011
`define OP_JAL           7'b1101111
`define OP_JALR          7'b1100111
`define OP_LOAD          7'b0000011
`define OP_STORE         7'b0100011
`define OP_SYSTEM        7'b1110011

// system function codes, carried in the csr_addr field
`define SYS_ECALL        12'h000
`define SYS_EBREAK       12'h001
`define SYS_MRET         12'h302

// csr operations, funct3 of the system opcode
`define CSRRW            4'd1
`define CSRRS            4'd2
`define CSRRC            4'd3
`define CSRRWI           4'd5
`define CSRRSI           4'd6
`define CSRRCI           4'd7

`define CSR_MSTATUS      12'h300
`define CSR_MTVEC        12'h305
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342

`define EXU_MTVEC_RESET  32'h0000_0100

`endif

//--- exu_pkg.sv
`include "exu_params.svh"

package exu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLE,
    ALU_SLEU
  } alu_op_e;

  // system view sits in the low 16 bits of the immediate
  typedef struct packed {
    logic [`EXU_XLEN-17:0] rsvd;
    logic [11:0]           csr_addr;
    logic [3:0]            csr_op;
  } sys_imm_t;

  typedef union packed {
    logic [`EXU_XLEN-1:0] plain;
    sys_imm_t             sys;
  } sys_imm_u;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] base;
    sys_imm_u             imm;
    logic [3:0]           rd;
    alu_op_e              alu_op;
    logic [6:0]           opcode;
    logic                 ren;
    logic                 wen;
    logic                 system;
    logic                 sys_func;
  } exu_issue_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] pc;
    logic [3:0]           rd;
    logic [`EXU_XLEN-1:0] rd_wdata;
    logic                 redirect;
    logic [`EXU_XLEN-1:0] npc;
    logic                 ebreak;
    logic                 retire_ctrl;
  } exu_result_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] addr;
    logic [`EXU_XLEN-1:0] wdata;
    logic                 we;
  } mem_req_t;

endpackage

//--- exu_alu.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  exu_pkg::alu_op_e     op_i,
  output logic [`EXU_XLEN-1:0] res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  // compares give 0 or 1 so branch resolution can test for nonzero
  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $signed(src1_i) >>> shamt;
      ALU_SLT:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      ALU_SLE:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s | eq};
      ALU_SLEU: res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

//--- exu_csr.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_csr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wen_i,
  input  logic [11:0]          waddr_i,
  input  logic [`EXU_XLEN-1:0] wdata_i,
  input  logic                 ecall_i,
  input  logic [`EXU_XLEN-1:0] epc_i,
  input  logic [11:0]          raddr_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  output logic [`EXU_XLEN-1:0] mtvec_o,
  output logic [`EXU_XLEN-1:0] mepc_o
);

  logic [`EXU_XLEN-1:0] mstatus_q;
  logic [`EXU_XLEN-1:0] mtvec_q;
  logic [`EXU_XLEN-1:0] mepc_q;
  logic [`EXU_XLEN-1:0] mcause_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= `EXU_MTVEC_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (wen_i) begin
        case (waddr_i)
          `CSR_MSTATUS: mstatus_q <= wdata_i;
          `CSR_MTVEC:   mtvec_q   <= wdata_i;
          `CSR_MEPC:    mepc_q    <= wdata_i;
          `CSR_MCAUSE:  mcause_q  <= wdata_i;
          default:      ;
        endcase
      end
      // trap entry saves the pc alongside the mcause write
      if (ecall_i) begin
        mepc_q <= epc_i;
      end
    end
  end

  always_comb begin
    case (raddr_i)
      `CSR_MSTATUS: rdata_o = mstatus_q;
      `CSR_MTVEC:   rdata_o = mtvec_q;
      `CSR_MEPC:    rdata_o = mepc_q;
      `CSR_MCAUSE:  rdata_o = mcause_q;
      default:      rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  a_waddr_known: assert property (@(posedge clk) disable iff (rst)
    wen_i |-> (waddr_i inside {`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE}));

  // ecall is always paired with the mcause write from branch/system logic
  a_ecall_with_cause: assert property (@(posedge clk) disable iff (rst)
    ecall_i |-> (wen_i && waddr_i == `CSR_MCAUSE));

endmodule

//--- exu_sys_branch.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_sys_branch (
  input  exu_pkg::exu_issue_t  inst_i,
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  logic [`EXU_XLEN-1:0] mtvec_i,
  input  logic [`EXU_XLEN-1:0] mepc_i,
  output logic                 csr_wen_o,
  output logic [11:0]          csr_addr_o,
  output logic [`EXU_XLEN-1:0] csr_wdata_o,
  output logic                 ecall_o,
  output logic                 redirect_o,
  output logic [`EXU_XLEN-1:0] npc_o,
  output logic                 ebreak_o
);
  import exu_pkg::*;

  localparam logic [`EXU_XLEN-1:0] CAUSE_ECALL_M = 11;

  logic [11:0]          func;
  logic [3:0]           csr_op;
  logic                 is_ecall;
  logic                 is_mret;
  logic                 is_csr;
  logic                 csr_op_ok;
  logic                 taken;
  logic [`EXU_XLEN-1:0] csr_rw_data;
  logic [`EXU_XLEN-1:0] mret_status;
  logic [`EXU_XLEN-1:0] target;

  assign func     = inst_i.imm.sys.csr_addr;
  assign csr_op   = inst_i.imm.sys.csr_op;
  assign is_ecall = inst_i.system & inst_i.sys_func & (func == `SYS_ECALL);
  assign is_mret  = inst_i.system & inst_i.sys_func & (func == `SYS_MRET);
  assign is_csr   = inst_i.system & ~inst_i.sys_func;
  assign ebreak_o = inst_i.system & inst_i.sys_func & (func == `SYS_EBREAK);
  assign target   = inst_i.base + inst_i.imm.plain;

  // op1 already holds the zero-extended uimm for the immediate forms
  always_comb begin
    csr_op_ok = 1'b1;
    case (csr_op)
      `CSRRW, `CSRRWI: csr_rw_data = inst_i.op1;
      `CSRRS, `CSRRSI: csr_rw_data = csr_rdata_i | inst_i.op1;
      `CSRRC, `CSRRCI: csr_rw_data = csr_rdata_i & ~inst_i.op1;
      default: begin
        csr_rw_data = '0;
        csr_op_ok   = 1'b0;
      end
    endcase
  end

  // mie <= mpie, mpie <= 1
  assign mret_status = {csr_rdata_i[`EXU_XLEN-1:8], 1'b1, csr_rdata_i[6:4],
                        csr_rdata_i[7], csr_rdata_i[2:0]};

  assign csr_addr_o  = is_ecall ? `CSR_MCAUSE : is_mret ? `CSR_MSTATUS : func;
  assign csr_wen_o   = is_ecall | is_mret | (is_csr & csr_op_ok);
  assign csr_wdata_o = is_ecall ? CAUSE_ECALL_M : is_mret ? mret_status : csr_rw_data;
  assign ecall_o     = is_ecall;

  always_comb begin
    case (inst_i.opcode)
      `OP_JAL, `OP_JALR: taken = 1'b1;
      // beq subtracts, the rest compare to a 0/1 flag
      `OP_BRANCH: taken = (inst_i.alu_op == ALU_SUB) ? ~|alu_res_i : |alu_res_i;
      default: taken = 1'b0;
    endcase
  end

  assign redirect_o = taken | is_ecall | is_mret;
  assign npc_o      = is_ecall ? mtvec_i : is_mret ? mepc_i : target;

endmodule

//--- exu_stage.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid_i,
  input  exu_pkg::exu_issue_t  issue_i,
  output logic                 issue_ready_o,
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output exu_pkg::exu_result_t result_o,
  output logic                 mem_req_valid_o,
  output exu_pkg::mem_req_t    mem_req_o,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i
);
  import exu_pkg::*;

  exu_issue_t           inst_q;
  logic                 busy_q;
  logic                 req_valid_q;
  logic                 mem_done_q;
  logic [`EXU_XLEN-1:0] rdata_q;
  logic                 is_mem;
  logic                 mem_resp;
  logic                 accept;
  logic                 consume;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic                 sb_csr_wen;
  logic [11:0]          sb_csr_addr;
  logic [`EXU_XLEN-1:0] sb_csr_wdata;
  logic                 sb_ecall;
  logic                 redirect;
  logic [`EXU_XLEN-1:0] npc;
  logic                 ebreak;
  logic [`EXU_XLEN-1:0] wb_data;

  assign is_mem         = inst_q.ren | inst_q.wen;
  assign mem_resp       = req_valid_q & (mem_rvalid_i | mem_wready_i);
  assign result_valid_o = busy_q & (~is_mem | mem_done_q);
  assign consume        = result_valid_o & result_ready_i;
  assign issue_ready_o  = ~busy_q | consume;
  assign accept         = issue_valid_i & issue_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
      mem_done_q  <= 1'b0;
    end else begin
      if (consume) begin
        busy_q     <= 1'b0;
        mem_done_q <= 1'b0;
      end
      if (mem_resp) begin
        req_valid_q <= 1'b0;
        mem_done_q  <= 1'b1;
      end
      if (accept) begin
        busy_q      <= 1'b1;
        req_valid_q <= issue_i.ren | issue_i.wen;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= issue_i;
    end
    if (req_valid_q & mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_req_valid_o = req_valid_q;
  assign mem_req_o.addr  = inst_q.base + inst_q.imm.plain;
  assign mem_req_o.wdata = inst_q.op2;
  assign mem_req_o.we    = inst_q.wen;

  exu_alu u_alu (
    .src1_i (inst_q.op1),
    .src2_i (inst_q.op2),
    .op_i   (inst_q.alu_op),
    .res_o  (alu_res)
  );

  exu_sys_branch u_sys_branch (
    .inst_i      (inst_q),
    .alu_res_i   (alu_res),
    .csr_rdata_i (csr_rdata),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .csr_wen_o   (sb_csr_wen),
    .csr_addr_o  (sb_csr_addr),
    .csr_wdata_o (sb_csr_wdata),
    .ecall_o     (sb_ecall),
    .redirect_o  (redirect),
    .npc_o       (npc),
    .ebreak_o    (ebreak)
  );

  // write only when the result leaves, once per instruction
  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (sb_csr_wen & consume),
    .waddr_i (sb_csr_addr),
    .wdata_i (sb_csr_wdata),
    .ecall_i (sb_ecall & consume),
    .epc_i   (inst_q.pc),
    .raddr_i (sb_csr_addr),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  always_comb begin
    if (inst_q.ren) begin
      wb_data = rdata_q;
    end else if (inst_q.system) begin
      wb_data = csr_rdata;
    end else if (inst_q.opcode == `OP_JAL || inst_q.opcode == `OP_JALR) begin
      wb_data = inst_q.pc + 'd4;
    end else begin
      wb_data = alu_res;
    end
  end

  assign result_o.pc          = inst_q.pc;
  assign result_o.rd          = inst_q.rd;
  assign result_o.rd_wdata    = (inst_q.rd != '0) ? wb_data : '0;
  assign result_o.redirect    = redirect;
  assign result_o.npc         = npc;
  assign result_o.ebreak      = ebreak;
  assign result_o.retire_ctrl = inst_q.system | (inst_q.opcode == `OP_BRANCH) |
                                (inst_q.opcode == `OP_LOAD);

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid_o && !mem_resp) |=> (mem_req_valid_o && $stable(mem_req_o)));

  a_result_stable: assert property (@(posedge clk) disable iff (rst)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o)));

  a_resp_has_req: assert property (@(posedge clk) disable iff (rst)
    (mem_rvalid_i || mem_wready_i) |-> mem_req_valid_o);

endmodule

//--- exu_dmem.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_dmem (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid_i,
  input  exu_pkg::mem_req_t    req_i,
  output logic                 rvalid_o,
  output logic                 wready_o,
  output logic [`EXU_XLEN-1:0] rdata_o
);

  localparam int AW = $clog2(`EXU_DMEM_WORDS);
  localparam int CW = $clog2(`EXU_DMEM_LAT + 1);

  logic [`EXU_XLEN-1:0] mem_q [`EXU_DMEM_WORDS];
  logic [AW-1:0]        idx;
  logic [CW-1:0]        cnt_q;
  logic                 busy_q;
  logic                 hold_q;

  assign idx = req_i.addr[AW+1:2];

  // unwritten words read back as zero
  initial begin
    for (int i = 0; i < `EXU_DMEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      hold_q   <= 1'b0;
      cnt_q    <= '0;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
    end else begin
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      if (hold_q) begin
        // wait for the old request to drop
        hold_q <= req_valid_i;
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q   <= 1'b0;
          hold_q   <= 1'b1;
          rvalid_o <= ~req_i.we;
          wready_o <= req_i.we;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (req_valid_i) begin
        busy_q <= 1'b1;
        cnt_q  <= CW'(`EXU_DMEM_LAT - 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy_q && cnt_q == '0) begin
      if (req_i.we) begin
        mem_q[idx] <= req_i.wdata;
      end
      rdata_o <= mem_q[idx];
    end
  end

endmodule

//--- exu_top.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid_i,
  input  exu_pkg::exu_issue_t  issue_i,
  output logic                 issue_ready_o,
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output exu_pkg::exu_result_t result_o
);
  import exu_pkg::*;

  logic                 mem_req_valid;
  mem_req_t             mem_req;
  logic                 mem_rvalid;
  logic                 mem_wready;
  logic [`EXU_XLEN-1:0] mem_rdata;

  exu_stage u_stage (
    .clk             (clk),
    .rst             (rst),
    .issue_valid_i   (issue_valid_i),
    .issue_i         (issue_i),
    .issue_ready_o   (issue_ready_o),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .result_o        (result_o),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rvalid_i    (mem_rvalid),
    .mem_wready_i    (mem_wready),
    .mem_rdata_i     (mem_rdata)
  );

  // word memory behind the load/store bus
  exu_dmem u_dmem (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .rvalid_o    (mem_rvalid),
    .wready_o    (mem_wready),
    .rdata_o     (mem_rdata)
  );

endmodule

//--- tb_exu.sv
`timescale 1ns/10ps
`include "exu_params.svh"

module tb_exu;
  import exu_pkg::*;

  localparam int N_INSTR    = 600;
  localparam int MAX_CYCLES = 40 * N_INSTR;

  logic        clk;
  logic        rst;
  logic        issue_valid_i;
  exu_issue_t  issue_i;
  logic        issue_ready_o;
  logic        result_valid_o;
  logic        result_ready_i;
  exu_result_t result_o;

  integer      seed;
  int          cycles;
  int          n_sent;
  int          n_checked;
  logic        issue_fire;
  logic        result_fire;
  logic [31:0] r;
  exu_issue_t  next_inst;
  exu_result_t next_exp;

  // reference model state
  logic [`EXU_XLEN-1:0] m_mstatus;
  logic [`EXU_XLEN-1:0] m_mtvec;
  logic [`EXU_XLEN-1:0] m_mepc;
  logic [`EXU_XLEN-1:0] m_mcause;
  logic [`EXU_XLEN-1:0] m_mem [`EXU_DMEM_WORDS];
  exu_result_t          exp_q[$];

  exu_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .issue_valid_i  (issue_valid_i),
    .issue_i        (issue_i),
    .issue_ready_o  (issue_ready_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $signed(a) >>> sh;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SLE:  return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] csr_get(logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS: return m_mstatus;
      `CSR_MTVEC:   return m_mtvec;
      `CSR_MEPC:    return m_mepc;
      default:      return m_mcause;
    endcase
  endfunction

  task automatic csr_put(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      `CSR_MSTATUS: m_mstatus = val;
      `CSR_MTVEC:   m_mtvec   = val;
      `CSR_MEPC:    m_mepc    = val;
      default:      m_mcause  = val;
    endcase
  endtask

  // first three are ecall, mret, ebreak, then a random mix
  function automatic int pick_kind(int idx);
    logic [31:0] rk;
    if (idx < 3) begin
      return 6 + idx;
    end
    rk = $random(seed);
    case (rk % 16)
      0, 1, 2, 3, 4: return 0;
      5, 6:          return 1;
      7:             return 2;
      8, 9:          return 3;
      10, 11:        return 4;
      12, 13:        return 5;
      14:            return rk[8] ? 7 : 6;
      default:       return 8;
    endcase
  endfunction

  task automatic make_instr(input int kind, output exu_issue_t inst, output exu_result_t exp);
    logic [31:0] rg;
    logic [31:0] wdata;
    logic [31:0] old_val;
    logic [7:0]  widx;
    logic [11:0] addr;
    logic [3:0]  op;
    inst = '0;
    exp = '0;
    wdata = '0;
    rg = $random(seed);
    inst.pc = {rg[31:2], 2'b00};
    rg = $random(seed);
    inst.rd = rg[3:0];
    inst.base = $random(seed);
    inst.imm.plain = $random(seed);
    inst.op1 = $random(seed);
    inst.op2 = $random(seed);
    rg = $random(seed);
    case (kind)
      0: begin
        inst.opcode = `OP_ALU;
        inst.alu_op = alu_op_e'(4'(rg % 12));
        wdata = alu_model(inst.alu_op, inst.op1, inst.op2);
      end
      1: begin
        inst.opcode = `OP_BRANCH;
        inst.rd = '0;
        if (rg[8]) begin
          inst.op2 = inst.op1;
        end
        case (rg % 6)
          0: inst.alu_op = ALU_SUB;
          1: inst.alu_op = ALU_XOR;
          2: inst.alu_op = ALU_SLT;
          3: inst.alu_op = ALU_SLTU;
          4: inst.alu_op = ALU_SLE;
          default: inst.alu_op = ALU_SLEU;
        endcase
        // beq taken on equal, the others on a true compare
        case (inst.alu_op)
          ALU_SUB:  exp.redirect = inst.op1 == inst.op2;
          ALU_XOR:  exp.redirect = inst.op1 != inst.op2;
          ALU_SLT:  exp.redirect = $signed(inst.op1) < $signed(inst.op2);
          ALU_SLTU: exp.redirect = inst.op1 < inst.op2;
          ALU_SLE:  exp.redirect = $signed(inst.op1) <= $signed(inst.op2);
          default:  exp.redirect = inst.op1 <= inst.op2;
        endcase
        exp.npc = inst.base + inst.imm.plain;
        exp.retire_ctrl = 1'b1;
      end
      2: begin
        inst.opcode = rg[0] ? `OP_JAL : `OP_JALR;
        wdata = inst.pc + 32'd4;
        exp.redirect = 1'b1;
        exp.npc = inst.base + inst.imm.plain;
      end
      3: begin
        inst.opcode = `OP_SYSTEM;
        inst.system = 1'b1;
        case (rg[1:0])
          2'd0: addr = `CSR_MSTATUS;
          2'd1: addr = `CSR_MTVEC;
          2'd2: addr = `CSR_MEPC;
          default: addr = `CSR_MCAUSE;
        endcase
        case (rg[4:2] % 6)
          0: op = `CSRRW;
          1: op = `CSRRS;
          2: op = `CSRRC;
          3: op = `CSRRWI;
          4: op = `CSRRSI;
          default: op = `CSRRCI;
        endcase
        inst.imm = '0;
        inst.imm.sys.csr_addr = addr;
        inst.imm.sys.csr_op = op;
        if (op >= `CSRRWI) begin
          inst.op1 = {27'b0, rg[9:5]};
        end
        old_val = csr_get(addr);
        wdata = old_val;
        case (op)
          `CSRRW, `CSRRWI: csr_put(addr, inst.op1);
          `CSRRS, `CSRRSI: csr_put(addr, old_val | inst.op1);
          default:         csr_put(addr, old_val & ~inst.op1);
        endcase
        exp.retire_ctrl = 1'b1;
      end
      4, 5: begin
        widx = {2'b00, rg[5:0]};
        inst.imm.plain = {27'b0, rg[10:8], 2'b00};
        inst.base = {22'b0, widx, 2'b00} - inst.imm.plain;
        inst.alu_op = ALU_ADD;
        if (kind == 4) begin
          inst.opcode = `OP_STORE;
          inst.wen = 1'b1;
          inst.rd = '0;
          m_mem[widx] = inst.op2;
        end else begin
          inst.opcode = `OP_LOAD;
          inst.ren = 1'b1;
          wdata = m_mem[widx];
          exp.retire_ctrl = 1'b1;
        end
      end
      default: begin
        inst.opcode = `OP_SYSTEM;
        inst.system = 1'b1;
        inst.sys_func = 1'b1;
        inst.rd = '0;
        inst.imm = '0;
        exp.retire_ctrl = 1'b1;
        if (kind == 6) begin
          inst.imm.sys.csr_addr = `SYS_ECALL;
          exp.redirect = 1'b1;
          exp.npc = m_mtvec;
          m_mepc = inst.pc;
          m_mcause = 32'd11;
        end else if (kind == 7) begin
          inst.imm.sys.csr_addr = `SYS_MRET;
          exp.redirect = 1'b1;
          exp.npc = m_mepc;
          // mie from mpie, mpie set
          m_mstatus[3] = m_mstatus[7];
          m_mstatus[7] = 1'b1;
        end else begin
          inst.imm.sys.csr_addr = `SYS_EBREAK;
          exp.ebreak = 1'b1;
        end
      end
    endcase
    exp.pc = inst.pc;
    exp.rd = inst.rd;
    exp.rd_wdata = (inst.rd != '0) ? wdata : '0;
  endtask

  task automatic check_result(input exu_result_t got);
    exu_result_t exp;
    logic        ok;
    assert (exp_q.size() > 0) else begin
      $display("a result came out with no instruction outstanding at %0t", $time);
      $display("Simulation failed");
      $fatal(1, "unexpected result");
    end
    exp = exp_q.pop_front();
    ok = (got.pc == exp.pc) && (got.rd == exp.rd) && (got.rd_wdata == exp.rd_wdata) &&
         (got.redirect == exp.redirect) && (got.ebreak == exp.ebreak) &&
         (got.retire_ctrl == exp.retire_ctrl) && (!exp.redirect || got.npc == exp.npc);
    assert (ok) else begin
      $display("FAIL at %0t: pc %h expected rd %0d data %h redirect %0b npc %h ebreak %0b",
               $time, exp.pc, exp.rd, exp.rd_wdata, exp.redirect, exp.npc, exp.ebreak);
      $display("  got pc %h rd %0d data %h redirect %0b npc %h ebreak %0b ctrl %0b/%0b",
               got.pc, got.rd, got.rd_wdata, got.redirect, got.npc, got.ebreak,
               exp.retire_ctrl, got.retire_ctrl);
      $display("Simulation failed");
      $fatal(1, "result mismatch");
    end
  endtask

  initial begin
    seed = 32'hd66b;
    cycles = 0;
    n_sent = 0;
    n_checked = 0;
    rst = 1'b1;
    issue_valid_i = 1'b0;
    issue_i = '0;
    result_ready_i = 1'b0;
    m_mstatus = '0;
    m_mtvec = `EXU_MTVEC_RESET;
    m_mepc = '0;
    m_mcause = '0;
    for (int i = 0; i < `EXU_DMEM_WORDS; i++) begin
      m_mem[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    while (n_checked < N_INSTR) begin
      // sample mid-cycle, drive on the next rising edge
      @(negedge clk);
      cycles++;
      assert (cycles < MAX_CYCLES) else begin
        $display("timeout: %0d of %0d results after %0d cycles", n_checked, N_INSTR, cycles);
        $display("Simulation failed");
        $fatal(1, "timeout");
      end
      result_fire = result_valid_o & result_ready_i;
      issue_fire = issue_valid_i & issue_ready_o;
      if (result_fire) begin
        check_result(result_o);
        n_checked++;
      end
      @(posedge clk);
      if (issue_fire) begin
        issue_valid_i <= 1'b0;
      end
      if ((issue_fire || !issue_valid_i) && n_sent < N_INSTR) begin
        r = $random(seed);
        // occasional idle cycle between issues
        if (r[2:0] != 3'd0) begin
          make_instr(pick_kind(n_sent), next_inst, next_exp);
          exp_q.push_back(next_exp);
          issue_i <= next_inst;
          issue_valid_i <= 1'b1;
          n_sent++;
        end
      end
      r = $random(seed);
      result_ready_i <= (r % 3) != 0;
    end

    repeat (10) begin
      @(negedge clk);
      assert (!result_valid_o) else begin
        $display("an extra result came out after the last instruction at %0t", $time);
        $display("Simulation failed");
        $fatal(1, "extra result");
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
exu_pkg.sv
exu_alu.sv
exu_csr.sv
exu_sys_branch.sv
exu_stage.sv
exu_dmem.sv
exu_top.sv
tb_exu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_exu
FILELIST   ?= compile.f
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "no final status in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
